// ==== design/raw_byte_collector.sv ====
// --------------------
// Packs accepted samples into bytes, MSB first, and hands each to the UART
// Samples are dropped while failure is high and for one cycle after it
// --------------------
`timescale 1ns/100ps

module raw_byte_collector (
    input  logic                       TRNG_Clock,
    input  logic                       TRNG_Enable,
    input  logic                       sample_bit,
    input  logic                       failure,
    input  logic                       tx_busy,
    output logic                       tx_start,    // One-cycle request
    output trng_cfg_pkg::sample_byte_t tx_data
);

    import trng_cfg_pkg::*;

    localparam int CNT_W = $clog2(BYTE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(BYTE_W - 1);

    collect_state_t state;
    logic [CNT_W-1:0] bit_count;    // Accepted bits in this byte
    logic             discard;      // Skip one sample after a failure
    sample_byte_t     shift_reg;
    logic             accept;       // Sample goes into the byte
    logic             send_ok;      // UART free, no pulse in flight

    assign accept  = (state == COLLECT_BITS) && !failure && !discard;
    assign send_ok = !tx_busy && !tx_start;

    // --------------------
    // Control FSM
    // --------------------
    always_ff @(posedge TRNG_Clock or negedge TRNG_Enable) begin
        if (!TRNG_Enable) begin
            state     <= COLLECT_IDLE;
            bit_count <= '0;
            discard   <= 1'b0;
            tx_start  <= 1'b0;
        end else begin
            tx_start <= 1'b0;                       // Default, pulse lasts one cycle

            case (state)
                COLLECT_IDLE: begin
                    bit_count <= '0;
                    state     <= COLLECT_BITS;
                end

                COLLECT_BITS: begin
                    if (failure) begin
                        bit_count <= '0;            // Partial byte thrown away
                        discard   <= 1'b1;
                    end else if (discard) begin
                        discard <= 1'b0;            // First sample after failure
                    end else begin
                        bit_count <= bit_count + CNT_W'(1);
                        if (bit_count == LAST_BIT) begin
                            state <= SEND_BYTE;     // Byte complete
                        end
                    end
                end

                SEND_BYTE: begin
                    // Samples arriving here are lost
                    if (send_ok) begin
                        tx_start  <= 1'b1;
                        bit_count <= '0;
                        state     <= COLLECT_BITS;
                    end
                end

                default: state <= COLLECT_IDLE;
            endcase
        end
    end

    // --------------------
    // Byte shift register
    // --------------------
    // New bits enter at the LSB, so the first one ends as MSB
    always_ff @(posedge TRNG_Clock) begin
        if (accept) begin
            shift_reg <= {shift_reg[BYTE_W-2:0], sample_bit};
        end
    end

    // Held stable through SEND_BYTE and the start pulse
    assign tx_data = shift_reg;

endmodule

// ==== design/rct_health_test.sv ====
// --------------------
// Noise bit synchronizer and sampler with the Repetition Count Test
// failure is high while the current run of equal samples reaches CUTOFF
// --------------------
`timescale 1ns/100ps

module rct_health_test #(
    parameter int CUTOFF = trng_cfg_pkg::DEFAULT_RCT_CUTOFF
) (
    input  logic TRNG_Clock,
    input  logic TRNG_Enable,
    input  logic noise_in,      // Asynchronous entropy bit
    output logic sample_bit,    // Synchronized sample
    output logic failure        // Run too long, aligned with sample_bit
);

    import trng_cfg_pkg::*;

    // Cutoff at counter width
    localparam logic [RUN_COUNT_W-1:0] CUTOFF_CNT = RUN_COUNT_W'(CUTOFF);

    logic                   sync_ff;    // First synchronizer stage
    logic                   sample_q;   // Second stage, doubles as sampler
    logic [RUN_COUNT_W-1:0] run_count;  // Length of the current run
    logic                   new_differs;

    // --------------------
    // Synchronizer
    // --------------------
    always_ff @(posedge TRNG_Clock or negedge TRNG_Enable) begin
        if (!TRNG_Enable) begin
            sync_ff  <= 1'b0;
            sample_q <= 1'b0;
        end else begin
            sync_ff  <= noise_in;
            sample_q <= sync_ff;
        end
    end

    assign sample_bit = sample_q;

    // Incoming sample against the one held in sample_q
    assign new_differs = sync_ff ^ sample_q;

    // --------------------
    // Run counter
    // --------------------
    // Updates on the same edge as sample_q, so the count
    // always describes the run ending in sample_bit
    always_ff @(posedge TRNG_Clock or negedge TRNG_Enable) begin
        if (!TRNG_Enable) begin
            run_count <= '0;
        end else if (new_differs) begin
            run_count <= RUN_COUNT_W'(1);                   // New run starts
        end else if (run_count < CUTOFF_CNT) begin
            run_count <= run_count + RUN_COUNT_W'(1);
        end
        // Saturates at the cutoff
    end

    // Repeat failure decode
    assign failure = (run_count >= CUTOFF_CNT);

endmodule

// ==== design/trng_cfg_pkg.sv ====
// --------------------
// Shared widths, types and defaults for the raw TRNG datapath
// Imported by the health test, the byte collector and the top level
// --------------------

package trng_cfg_pkg;

    // --------------------
    // Byte packing
    // --------------------
    localparam int BYTE_W = 8;                  // Bits per output byte

    typedef logic [BYTE_W-1:0] sample_byte_t;   // One collected byte

    // Collector FSM encoding
    typedef enum logic [1:0] {
        COLLECT_IDLE = 2'b00,                   // One cycle after reset
        COLLECT_BITS = 2'b01,                   // Shifting in accepted samples
        SEND_BYTE    = 2'b10                    // Waiting for the UART
    } collect_state_t;

    // --------------------
    // Repetition Count Test
    // --------------------
    localparam int DEFAULT_RCT_CUTOFF = 32;     // Run length that flags a failure
    localparam int RUN_COUNT_W        = 6;      // Holds cutoffs up to 63

endpackage

// ==== design/trng_top.sv ====
// --------------------
// Raw-output TRNG top level
// Noise bit in, health failure flag and UART byte stream out
// --------------------
`timescale 1ns/100ps

module trng_top #(
    parameter int CUTOFF        = trng_cfg_pkg::DEFAULT_RCT_CUTOFF,
    parameter int TICKS_PER_BIT = uart_pkg::DEFAULT_TICKS_PER_BIT
) (
    input  logic TRNG_Clock,
    input  logic TRNG_Enable,   // Active low reset
    input  logic noise_in,      // External entropy source
    output logic failure,       // Repetition Count Test flag
    output logic uart_tx        // 8N1 serial output
);

    import trng_cfg_pkg::*;

    logic         sample_bit;
    logic         tx_start;
    logic         tx_busy;
    sample_byte_t tx_data;

    // --------------------
    // Sampling and health test
    // --------------------
    rct_health_test #(
        .CUTOFF(CUTOFF)
    ) u_rct (
        .TRNG_Clock (TRNG_Clock),
        .TRNG_Enable(TRNG_Enable),
        .noise_in   (noise_in),
        .sample_bit (sample_bit),
        .failure    (failure)
    );

    // Byte packing
    raw_byte_collector u_collector (
        .TRNG_Clock (TRNG_Clock),
        .TRNG_Enable(TRNG_Enable),
        .sample_bit (sample_bit),
        .failure    (failure),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_data    (tx_data)
    );

    // Serial output
    uart_tx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) u_uart_tx (
        .TRNG_Clock (TRNG_Clock),
        .TRNG_Enable(TRNG_Enable),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .tx_busy    (tx_busy),
        .uart_tx    (uart_tx)
    );

endmodule

// ==== design/uart_pkg.sv ====
// --------------------
// UART frame constants and transmitter state encoding
// Used by the transmitter and by the top level parameter defaults
// --------------------

package uart_pkg;

    // --------------------
    // Frame format
    // --------------------
    // 8N1 framing
    // start bit, eight data bits, stop bit
    localparam int UART_FRAME_BITS = 10;

    // 115200 baud from a 50 MHz clock
    localparam int DEFAULT_TICKS_PER_BIT = 435;

    // --------------------
    // Transmitter FSM
    // --------------------
    typedef enum logic [1:0] {
        UART_IDLE  = 2'b00,     // Line high, ready for a byte
        UART_START = 2'b01,     // Driving the start bit
        UART_DATA  = 2'b10,     // Data bits, LSB first
        UART_STOP  = 2'b11      // Driving the stop bit
    } uart_state_t;

endpackage

// ==== design/uart_tx.sv ====
// --------------------
// 8N1 UART transmitter, one byte per tx_start pulse
// tx_busy covers the whole frame, tx_start while busy is ignored
// --------------------
`timescale 1ns/100ps

module uart_tx #(
    parameter int TICKS_PER_BIT = uart_pkg::DEFAULT_TICKS_PER_BIT
) (
    input  logic                       TRNG_Clock,
    input  logic                       TRNG_Enable,
    input  logic                       tx_start,
    input  trng_cfg_pkg::sample_byte_t tx_data,
    output logic                       tx_busy,
    output logic                       uart_tx     // Serial line, idles high
);

    import trng_cfg_pkg::*;
    import uart_pkg::*;

    localparam int TICK_W = (TICKS_PER_BIT > 1) ? $clog2(TICKS_PER_BIT) : 1;
    localparam int IDX_W  = $clog2(BYTE_W);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(TICKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0]  LAST_IDX  = IDX_W'(BYTE_W - 1);

    uart_state_t       state;
    logic [TICK_W-1:0] tick_count;  // Cycles into the current bit
    logic [IDX_W-1:0]  bit_idx;     // Data bit being sent
    sample_byte_t      data_q;      // Byte under transmission
    logic              load;        // Accept a new byte
    logic              bit_done;    // Last cycle of a bit time

    assign load     = (state == UART_IDLE) && tx_start;
    assign bit_done = (tick_count == LAST_TICK);

    // Byte latch
    always_ff @(posedge TRNG_Clock) begin
        if (load) begin
            data_q <= tx_data;
        end
    end

    // --------------------
    // Frame FSM
    // --------------------
    always_ff @(posedge TRNG_Clock or negedge TRNG_Enable) begin
        if (!TRNG_Enable) begin
            state      <= UART_IDLE;
            tick_count <= '0;
            bit_idx    <= '0;
            tx_busy    <= 1'b0;
            uart_tx    <= 1'b1;
        end else begin
            if (state != UART_IDLE) begin
                tick_count <= bit_done ? '0 : tick_count + TICK_W'(1);
            end

            case (state)
                UART_IDLE: begin
                    if (tx_start) begin
                        state      <= UART_START;
                        tick_count <= '0;
                        tx_busy    <= 1'b1;
                        uart_tx    <= 1'b0;         // Start bit
                    end
                end

                UART_START: if (bit_done) begin
                    state   <= UART_DATA;
                    bit_idx <= '0;
                    uart_tx <= data_q[0];           // LSB first
                end

                UART_DATA: if (bit_done) begin
                    if (bit_idx == LAST_IDX) begin
                        state   <= UART_STOP;
                        uart_tx <= 1'b1;            // Stop bit
                    end else begin
                        bit_idx <= bit_idx + IDX_W'(1);
                        uart_tx <= data_q[bit_idx + IDX_W'(1)];
                    end
                end

                UART_STOP: if (bit_done) begin
                    state   <= UART_IDLE;
                    tx_busy <= 1'b0;                // Frame finished
                end

                default: state <= UART_IDLE;
            endcase
        end
    end

endmodule

// ==== files.f ====
design/trng_cfg_pkg.sv
design/uart_pkg.sv
design/rct_health_test.sv
design/raw_byte_collector.sv
design/uart_tx.sv
design/trng_top.sv
verification/trng_chk.sv
verification/tb_trng.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the TRNG testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_trng -f files.f

out=$(./obj_dir/Vtb_trng)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED'; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== verification/tb_trng.sv ====
// --------------------
// Testbench for the raw TRNG, cycle model against UART frame decoder
// Runs reset, random bytes, repetition failure, resume and back-pressure
// --------------------
`timescale 1ns/100ps

module tb_trng;

    import trng_cfg_pkg::*;
    import uart_pkg::*;

    localparam int CUTOFF         = 8;
    localparam int TICKS          = 4;                      // Cycles per UART bit
    localparam int FRAME_CYC      = UART_FRAME_BITS * TICKS;
    localparam int RESET_CYC      = 16;
    localparam int RUN_LEN        = 20;                     // Constant run length
    localparam int RISE_DELAY     = 2 + CUTOFF - 1;         // Two flops, then CUTOFF-1 repeats
    localparam int FALL_DELAY     = 2;                      // Two flops only
    localparam int ALIGN_BUSY     = RISE_DELAY + 1;         // Failure lands inside a byte
    localparam int RANDOM_BYTES   = 8;
    localparam int RESUME_BYTES   = 4;
    localparam int PRESSURE_BYTES = 6;
    localparam int CYCLE_LIMIT    =
        (RANDOM_BYTES + RESUME_BYTES + PRESSURE_BYTES) * (FRAME_CYC + 20) + 2000;

    // Collector phases of the model
    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_BITS = 2'd1;
    localparam logic [1:0] PH_SEND = 2'd2;

    typedef struct packed {
        logic              s1;          // First sync stage
        logic              s2;          // Current sample
        int                run;         // Equal samples so far
        logic [1:0]        phase;
        int                bits;        // Accepted bits in byte
        logic              discard;
        logic [BYTE_W-1:0] shreg;
        logic              start;       // Request pulse
        int                busy;        // Cycles left in frame
    } model_t;

    logic TRNG_Clock;
    logic TRNG_Enable;
    logic noise_in;
    logic failure;
    logic uart_tx;

    int                seed        = 32'h13ee_72fc;
    int                checks      = 0;
    int                errors      = 0;
    int                cycle_count = 0;
    int                decoded     = 0;
    int                compared    = 0;
    int                last_start  = 0;
    model_t            model;
    logic [BYTE_W-1:0] exp_q[$];    // Bytes the model has sent
    logic [BYTE_W-1:0] got_q[$];    // Bytes read off the line
    logic [BYTE_W-1:0] frame_byte;
    logic [BYTE_W-1:0] got_byte;
    logic [BYTE_W-1:0] exp_byte;

    trng_top #(
        .CUTOFF       (CUTOFF),
        .TICKS_PER_BIT(TICKS)
    ) DUT (
        .TRNG_Clock (TRNG_Clock),
        .TRNG_Enable(TRNG_Enable),
        .noise_in   (noise_in),
        .failure    (failure),
        .uart_tx    (uart_tx)
    );

    initial begin
        TRNG_Clock = 1'b0;
        forever #50 TRNG_Clock = ~TRNG_Clock;   // 100 ns period
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic model_t reset_model();
        model_t m;
        m       = '0;
        m.phase = PH_IDLE;
        return m;
    endfunction

    // One clock edge of sampler, health test, collector and UART busy
    function automatic model_t next_model(input model_t m, input logic noise);
        model_t n;
        logic   fail;
        n       = m;
        fail    = (m.run >= CUTOFF);
        n.s1    = noise;
        n.s2    = m.s1;
        n.start = 1'b0;
        if (m.s1 != m.s2) begin
            n.run = 1;                          // Run restarts
        end else if (m.run < CUTOFF) begin
            n.run = m.run + 1;
        end
        case (m.phase)
            PH_IDLE: n.phase = PH_BITS;
            PH_BITS: begin
                if (fail) begin
                    n.bits    = 0;              // Partial byte lost
                    n.discard = 1'b1;
                end else if (m.discard) begin
                    n.discard = 1'b0;           // One sample skipped
                end else begin
                    n.shreg = {m.shreg[BYTE_W-2:0], m.s2};
                    n.bits  = m.bits + 1;
                    if (n.bits == BYTE_W) begin
                        n.phase = PH_SEND;
                    end
                end
            end
            default: begin
                if (m.busy == 0 && !m.start) begin
                    n.start = 1'b1;
                    n.bits  = 0;
                    n.phase = PH_BITS;
                end
            end
        endcase
        // Busy rises the edge after the pulse and lasts one frame
        if (m.busy > 0) begin
            n.busy = m.busy - 1;
        end else if (m.start) begin
            n.busy = FRAME_CYC;
        end
        return n;
    endfunction

    always @(posedge TRNG_Clock or negedge TRNG_Enable) begin
        if (!TRNG_Enable) begin
            model = reset_model();
        end else begin
            model = next_model(model, noise_in);
            if (model.start) begin
                exp_q.push_back(model.shreg);   // Byte handed to the UART
            end
        end
    end

    // --------------------
    // Check helpers
    // --------------------
    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input logic [BYTE_W-1:0] expected,
                              input logic [BYTE_W-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - err_mark);
        end
    endtask

    // Called right after a falling edge
    task automatic drive_random();
        int rnd;
        rnd      = $random(seed);
        noise_in = rnd[0];
    endtask

    // Byte counts only move on falling edges, read them on rising ones
    task automatic wait_bytes(input int n);
        int target;
        @(posedge TRNG_Clock);
        target = compared + n;
        while (compared < target) begin
            @(negedge TRNG_Clock);
            drive_random();
            @(posedge TRNG_Clock);
        end
    endtask

    // --------------------
    // UART decoder
    // --------------------
    always begin
        @(negedge TRNG_Clock);
        if (TRNG_Enable && uart_tx === 1'b0) begin
            if (decoded > 0) begin
                check_true(cycle_count - last_start >= FRAME_CYC,
                           "UART frame started before the previous one ended");
            end
            last_start = cycle_count;
            repeat (TICKS / 2) @(negedge TRNG_Clock);   // Middle of start bit
            check_true(uart_tx === 1'b0, "start bit not low in the middle of its bit time");
            for (int i = 0; i < BYTE_W; i++) begin
                repeat (TICKS) @(negedge TRNG_Clock);
                frame_byte = {uart_tx, frame_byte[BYTE_W-1:1]};  // LSB first
            end
            repeat (TICKS) @(negedge TRNG_Clock);
            check_true(uart_tx === 1'b1, "stop bit not high in the middle of its bit time");
            @(posedge TRNG_Clock);                      // Still inside the stop bit
            got_q.push_back(frame_byte);
            decoded++;
        end
    end

    // Comparison against the model, once per cycle
    always @(negedge TRNG_Clock) begin
        check_bit("failure", model.run >= CUTOFF, failure);
        if (got_q.size() > 0) begin
            got_byte = got_q.pop_front();
            check_true(exp_q.size() > 0, "UART frame arrived with no byte pending in the model");
            if (exp_q.size() > 0) begin
                exp_byte = exp_q.pop_front();
                check_byte("uart_tx byte", exp_byte, got_byte);
            end
            compared++;
        end
    end

    // Run limit
    always @(posedge TRNG_Clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped sending bytes", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        int err_mark;
        int rise_at;
        TRNG_Enable = 1'b0;
        noise_in    = 1'b0;

        // Reset state, line idle and no failure
        err_mark = errors;
        repeat (RESET_CYC) begin
            @(negedge TRNG_Clock);
            check_bit("failure", 1'b0, failure);
            check_bit("uart_tx", 1'b1, uart_tx);
        end
        TRNG_Enable = 1'b1;
        repeat (4) begin                        // Too short for a byte
            @(negedge TRNG_Clock);
            check_bit("failure", 1'b0, failure);
            check_bit("uart_tx", 1'b1, uart_tx);
        end
        report_test("reset state", err_mark);

        err_mark = errors;
        wait_bytes(RANDOM_BYTES);
        report_test("random raw bytes", err_mark);

        err_mark = errors;
        rise_at  = -1;
        // Frame end sets where the next byte starts collecting
        do begin
            @(negedge TRNG_Clock);
            drive_random();
        end while (model.busy != ALIGN_BUSY);
        // Alternating preamble clears any earlier run
        for (int i = 0; i < 4; i++) begin
            @(negedge TRNG_Clock);
            noise_in = i[0];                    // Ends on a one
        end
        for (int i = 0; i < RUN_LEN; i++) begin
            @(negedge TRNG_Clock);
            noise_in = 1'b0;
            check_bit("failure", i >= RISE_DELAY, failure);
            if (failure === 1'b1 && rise_at < 0) begin
                rise_at = i;
            end
        end
        check_true(rise_at == RISE_DELAY, "failure did not rise on the CUTOFF-th equal sample");
        for (int j = 0; j < 4; j++) begin
            @(negedge TRNG_Clock);
            if (j == 0) begin
                noise_in = 1'b1;                // First differing bit
            end else begin
                drive_random();
            end
            check_bit("failure", j < FALL_DELAY, failure);
        end
        report_test("repetition failure", err_mark);

        err_mark = errors;
        wait_bytes(RESUME_BYTES);
        report_test("discard and resume", err_mark);

        err_mark = errors;
        wait_bytes(PRESSURE_BYTES);
        report_test("back-pressure", err_mark);

        $display("Summary: %0d checks, %0d errors, %0d bytes decoded", checks, errors, decoded);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/trng_chk.sv ====
// --------------------
// Handshake and line assertions for the UART request path
// Bound into the transmitter, where request, busy and line all meet
// --------------------
`timescale 1ns/100ps

module trng_chk (
    input logic TRNG_Clock,
    input logic TRNG_Enable,
    input logic tx_start,       // Request pulse from the collector
    input logic tx_busy,        // Frame in progress
    input logic serial_line     // Transmitter output
);

    // --------------------
    // Request pulse
    // --------------------
    a_start_one_cycle: assert property (
        @(posedge TRNG_Clock) disable iff (!TRNG_Enable)
        tx_start |=> !tx_start
    ) else $error("tx_start high for two consecutive cycles");

    a_start_not_busy: assert property (
        @(posedge TRNG_Clock) disable iff (!TRNG_Enable)
        !(tx_start && tx_busy)
    ) else $error("tx_start raised while the transmitter is busy");

    // Line idles high between frames
    a_idle_line_high: assert property (
        @(posedge TRNG_Clock) disable iff (!TRNG_Enable)
        !tx_busy |-> serial_line
    ) else $error("uart_tx low while the transmitter is idle");

endmodule

bind uart_tx trng_chk u_chk (
    .TRNG_Clock (TRNG_Clock),
    .TRNG_Enable(TRNG_Enable),
    .tx_start   (tx_start),
    .tx_busy    (tx_busy),
    .serial_line(uart_tx)
);
